/* design/portalConsts.svh */
`ifndef PORTAL_CONSTS_SVH
`define PORTAL_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths
`define DATA_W 32
`define ID_W 6
`define LEN_W 4
`define OFFS_W 5
`define CNT_W 10

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Address decode
`define PORT_BIT 12
`define CTRL_HI 11
`define CTRL_LO 5
`define INT_ENABLE_OFFS 4

// Information words seen in the control window
`define IND_PORTAL_ID 5
`define REQ_PORTAL_ID 6
`define PORTAL_COUNT 2
`define TOP_FLAG 1
`define DEFAULT_WORD 'h005A05A0

`endif

/* design/portalPkg.sv */
`include "portalConsts.svh"

package portalPkg;

  // Address bit 12 picks the portal
  typedef enum logic {
    indicationPort = 1'b0,
    requestPort    = 1'b1
  } portSelT;

  // One accepted AR or AW burst with its flags carried along
  typedef struct packed {
    logic [`OFFS_W-1:0] offset;
    logic [`CNT_W-1:0]  count;   // Beat count that is never zero
    logic [`ID_W-1:0]   id;
    portSelT            port;
    logic               ctrl;
    logic [1:0]         method;
  } burstReqT;

  typedef struct packed {
    logic [`OFFS_W-1:0] offset;
    logic [`ID_W-1:0]   id;
    portSelT            port;
    logic               ctrl;
    logic [1:0]         method;
    logic               last;
  } beatT;

  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic [`ID_W-1:0]   id;
  } readDataT;

endpackage

/* design/smallFifo.sv */
`timescale 1ns/1ps

module smallFifo #(
  parameter type payloadT = logic,
  parameter int depth = 2
) (
  input  logic    CLK,
  input  logic    RST_N,
  input  logic    enq,
  input  payloadT enqData,
  input  logic    deq,
  output payloadT deqData,
  output logic    notFull,
  output logic    notEmpty
);

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
  localparam int fillW = $clog2(depth + 1);

  payloadT mem [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [fillW-1:0] fill;

  assign notFull = fill != fillW'(depth);
  assign notEmpty = fill != '0;
  assign deqData = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (enq) begin
      mem[wrPtr] <= enqData;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill <= '0;
    end else begin
      if (enq) begin
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + ptrW'(1);
      end
      if (deq) begin
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + ptrW'(1);
      end
      fill <= fill + fillW'(enq) - fillW'(deq);
    end
  end

  // Callers look at the flags before they push or pop
  assert property (@(posedge CLK) disable iff (!RST_N) enq |-> notFull)
    else $error("smallFifo: enq while full");
  assert property (@(posedge CLK) disable iff (!RST_N) deq |-> notEmpty)
    else $error("smallFifo: deq while empty");

endmodule

/* design/burstSplitter.sv */
`timescale 1ns/1ps

`include "portalConsts.svh"

module burstSplitter (
  input  logic               CLK,
  input  logic               RST_N,
  input  portalPkg::burstReqT burst,
  input  logic               burstValid,
  output logic               burstTaken,
  output portalPkg::beatT    beat,
  output logic               beatValid,
  input  logic               beatTaken
);

  logic first;  // Next beat is the first one of the burst at the head
  logic [`OFFS_W-1:0] offsetReg;
  logic [`CNT_W-1:0] countReg;
  logic [`OFFS_W-1:0] curOffset;
  logic [`CNT_W-1:0] curCount;
  logic isLast;

  assign curOffset = first ? burst.offset : offsetReg;
  assign curCount = first ? burst.count : countReg;
  assign isLast = curCount == `CNT_W'(1);

  assign beatValid = burstValid;
  assign beat.offset = curOffset;
  assign beat.id = burst.id;
  assign beat.port = burst.port;
  assign beat.ctrl = burst.ctrl;
  assign beat.method = burst.method;
  assign beat.last = isLast;

  // The burst item stays queued until its final beat leaves
  assign burstTaken = beatTaken && isLast;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      first <= 1'b1;
      countReg <= '0;
    end else if (beatTaken) begin
      first <= isLast;
      countReg <= curCount - `CNT_W'(1);
    end
  end

  always_ff @(posedge CLK) begin
    if (beatTaken) begin
      offsetReg <= curOffset + `OFFS_W'(4);  // Word step
    end
  end

  // A zero count would wrap the counter and run away
  assert property (@(posedge CLK) disable iff (!RST_N)
    (beatTaken && first) |-> burst.count != '0)
    else $error("burstSplitter: burst with zero beats");

endmodule

/* design/portalRegisters.sv */
`timescale 1ns/1ps

`include "portalConsts.svh"

module portalRegisters (
  input  logic                 CLK,
  input  logic                 RST_N,
  input  portalPkg::portSelT   readPort,
  input  logic [`OFFS_W-1:0]   readOffset,
  output logic [`DATA_W-1:0]   readWord,
  input  logic                 enableWrite,
  input  portalPkg::portSelT   writePort,
  input  logic                 enableValue,
  input  logic [`DATA_W-1:0]   indIntrChannel,
  input  logic [`DATA_W-1:0]   reqIntrChannel,
  output logic                 interrupt
);

  import portalPkg::*;

  logic [1:0] enableReg;  // Indexed by port
  logic [`DATA_W-1:0] channel;
  logic [`DATA_W-1:0] portalId;
  logic pending;

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      enableReg <= '0;
    end else if (enableWrite) begin
      enableReg[writePort] <= enableValue;
    end
  end

  assign channel = (readPort == requestPort) ? reqIntrChannel : indIntrChannel;
  assign portalId = (readPort == requestPort) ? `REQ_PORTAL_ID : `IND_PORTAL_ID;
  assign pending = channel != '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control window readback
  always_comb begin
    case (readOffset)
      5'h00: readWord = {{(`DATA_W-1){1'b0}}, pending};
      5'h04: readWord = {{(`DATA_W-1){1'b0}}, enableReg[readPort]};
      5'h08: readWord = `TOP_FLAG;
      5'h0C: readWord = channel;
      5'h10: readWord = portalId;
      5'h14: readWord = `PORTAL_COUNT;
      5'h18, 5'h1C: readWord = '0;
      default: readWord = `DEFAULT_WORD;
    endcase
  end

  assign interrupt = (indIntrChannel != '0 && enableReg[indicationPort])
                  || (reqIntrChannel != '0 && enableReg[requestPort]);

endmodule

/* design/axiReadPath.sv */
`timescale 1ns/1ps

`include "portalConsts.svh"

module axiReadPath (
  input  logic                 CLK,
  input  logic                 RST_N,
  input  logic [31:0]          arAddr,
  input  logic [`ID_W-1:0]     arId,
  input  logic [`LEN_W-1:0]    arLen,
  input  logic                 arValid,
  output logic                 arReady,
  output logic [`DATA_W-1:0]   rData,
  output logic [`ID_W-1:0]     rId,
  output logic                 rValid,
  input  logic                 rReady,
  output logic [`OFFS_W-1:0]   ctrlOffset,
  output portalPkg::portSelT   ctrlPort,
  input  logic [`DATA_W-1:0]   ctrlWord,
  input  logic [`DATA_W-1:0]   indicationData,
  input  logic                 indicationNotEmpty,
  output logic                 indicationDeq,
  input  logic                 requestNotFull
);

  import portalPkg::*;

  burstReqT arBurst, burstHead;
  beatT beatIn, beatHead;
  readDataT rdIn, rdHead;
  logic burstNotEmpty, burstTaken;
  logic beatValid, beatPush, beatNotFull, beatNotEmpty, beatPop;
  logic rdNotFull;
  logic isIndData;
  logic [`DATA_W-1:0] methodWord;

  assign arBurst = '{
    offset: arAddr[`OFFS_W-1:0],
    count: `CNT_W'(arLen) + `CNT_W'(1),
    id: arId,
    port: portSelT'(arAddr[`PORT_BIT]),
    ctrl: arAddr[`CTRL_HI:`CTRL_LO] == '0,
    method: arAddr[6:5] - 2'd1
  };

  smallFifo #(.payloadT(burstReqT)) burstQ (
    .CLK(CLK), .RST_N(RST_N), .enq(arValid && arReady), .enqData(arBurst),
    .deq(burstTaken), .deqData(burstHead), .notFull(arReady), .notEmpty(burstNotEmpty));

  burstSplitter splitter (
    .CLK(CLK), .RST_N(RST_N), .burst(burstHead), .burstValid(burstNotEmpty),
    .burstTaken(burstTaken), .beat(beatIn), .beatValid(beatValid), .beatTaken(beatPush));

  assign beatPush = beatValid && beatNotFull;

  smallFifo #(.payloadT(beatT)) beatQ (
    .CLK(CLK), .RST_N(RST_N), .enq(beatPush), .enqData(beatIn),
    .deq(beatPop), .deqData(beatHead), .notFull(beatNotFull), .notEmpty(beatNotEmpty));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat service
  assign isIndData = !beatHead.ctrl && beatHead.port == indicationPort
                  && beatHead.offset == '0;
  assign beatPop = beatNotEmpty && rdNotFull && (!isIndData || indicationNotEmpty);
  assign indicationDeq = beatPop && isIndData;  // Data is consumed by the read

  assign ctrlOffset = beatHead.offset;
  assign ctrlPort = beatHead.port;

  always_comb begin
    methodWord = '0;
    if (beatHead.port == indicationPort) begin
      if (beatHead.offset == 5'h00) begin
        methodWord = indicationData;
      end else if (beatHead.offset == 5'h04) begin
        methodWord = {{(`DATA_W-1){1'b0}}, indicationNotEmpty};
      end
    end else if (beatHead.offset == 5'h04) begin
      methodWord = {{(`DATA_W-1){1'b0}}, requestNotFull};
    end
  end

  assign rdIn = '{data: beatHead.ctrl ? ctrlWord : methodWord, id: beatHead.id};

  smallFifo #(.payloadT(readDataT)) readDataQ (
    .CLK(CLK), .RST_N(RST_N), .enq(beatPop), .enqData(rdIn),
    .deq(rValid && rReady), .deqData(rdHead), .notFull(rdNotFull), .notEmpty(rValid));

  assign rData = rdHead.data;
  assign rId = rdHead.id;

endmodule

/* design/axiWritePath.sv */
`timescale 1ns/1ps

`include "portalConsts.svh"

module axiWritePath (
  input  logic                 CLK,
  input  logic                 RST_N,
  input  logic [31:0]          awAddr,
  input  logic [`ID_W-1:0]     awId,
  input  logic [`LEN_W-1:0]    awLen,
  input  logic                 awValid,
  output logic                 awReady,
  input  logic [`DATA_W-1:0]   wData,
  input  logic                 wLast,
  input  logic                 wValid,
  output logic                 wReady,
  output logic [`ID_W-1:0]     bId,
  output logic                 bValid,
  input  logic                 bReady,
  output logic [`DATA_W-1:0]   requestData,
  output logic [1:0]           requestSelect,
  output logic                 requestEnq,
  input  logic                 requestNotFull,
  output logic                 enableWrite,
  output portalPkg::portSelT   writePort,
  output logic                 enableValue
);

  import portalPkg::*;

  burstReqT awBurst, burstHead;
  beatT beatIn, beatHead;
  logic awFire, wFire, lastSeen;
  logic burstNotEmpty, burstTaken;
  logic beatValid, beatPush, beatNotFull, beatNotEmpty, beatPop;
  logic dataNotFull, dataNotEmpty;
  logic respNotFull, respEnq;
  logic isReq;

  assign awFire = awValid && awReady;
  assign wFire = wValid && wReady;

  assign awBurst = '{
    offset: awAddr[`OFFS_W-1:0],
    count: `CNT_W'(awLen) + `CNT_W'(1),
    id: awId,
    port: portSelT'(awAddr[`PORT_BIT]),
    ctrl: awAddr[`CTRL_HI:`CTRL_LO] == '0,
    method: awAddr[6:5] - 2'd1
  };

  smallFifo #(.payloadT(burstReqT)) burstQ (
    .CLK(CLK), .RST_N(RST_N), .enq(awFire), .enqData(awBurst),
    .deq(burstTaken), .deqData(burstHead), .notFull(awReady), .notEmpty(burstNotEmpty));

  burstSplitter splitter (
    .CLK(CLK), .RST_N(RST_N), .burst(burstHead), .burstValid(burstNotEmpty),
    .burstTaken(burstTaken), .beat(beatIn), .beatValid(beatValid), .beatTaken(beatPush));

  assign beatPush = beatValid && beatNotFull;

  smallFifo #(.payloadT(beatT)) beatQ (
    .CLK(CLK), .RST_N(RST_N), .enq(beatPush), .enqData(beatIn),
    .deq(beatPop), .deqData(beatHead), .notFull(beatNotFull), .notEmpty(beatNotEmpty));

  // Write data closes after WLAST until the next address arrives
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      lastSeen <= 1'b0;
    end else if (awFire) begin
      lastSeen <= 1'b0;
    end else if (wFire && wLast) begin
      lastSeen <= 1'b1;
    end
  end

  assign wReady = !lastSeen && dataNotFull;

  smallFifo #(.payloadT(logic [`DATA_W-1:0])) dataQ (
    .CLK(CLK), .RST_N(RST_N), .enq(wFire), .enqData(wData),
    .deq(beatPop), .deqData(requestData), .notFull(dataNotFull), .notEmpty(dataNotEmpty));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat service with one data word per beat
  assign isReq = !beatHead.ctrl && beatHead.port == requestPort;
  assign beatPop = beatNotEmpty && dataNotEmpty && (!beatHead.last || respNotFull)
                && (!isReq || requestNotFull);

  assign requestEnq = beatPop && isReq;
  assign requestSelect = beatHead.method;

  assign enableWrite = beatPop && beatHead.ctrl
                    && beatHead.offset == `OFFS_W'(`INT_ENABLE_OFFS);
  assign writePort = beatHead.port;
  assign enableValue = requestData[0];

  assign respEnq = beatPop && beatHead.last;

  smallFifo #(.payloadT(logic [`ID_W-1:0])) respQ (
    .CLK(CLK), .RST_N(RST_N), .enq(respEnq), .enqData(beatHead.id),
    .deq(bValid && bReady), .deqData(bId), .notFull(respNotFull), .notEmpty(bValid));

endmodule

/* design/portalTop.sv */
`timescale 1ns/1ps

`include "portalConsts.svh"

module portalTop (
  input  logic                 CLK,
  input  logic                 RST_N,
  input  logic [31:0]          arAddr,
  input  logic [`ID_W-1:0]     arId,
  input  logic [`LEN_W-1:0]    arLen,
  input  logic                 arValid,
  output logic                 arReady,
  output logic [`DATA_W-1:0]   rData,
  output logic [`ID_W-1:0]     rId,
  output logic                 rValid,
  input  logic                 rReady,
  input  logic [31:0]          awAddr,
  input  logic [`ID_W-1:0]     awId,
  input  logic [`LEN_W-1:0]    awLen,
  input  logic                 awValid,
  output logic                 awReady,
  input  logic [`DATA_W-1:0]   wData,
  input  logic                 wLast,
  input  logic                 wValid,
  output logic                 wReady,
  output logic [`ID_W-1:0]     bId,
  output logic                 bValid,
  input  logic                 bReady,
  output logic [`DATA_W-1:0]   requestData,
  output logic [1:0]           requestSelect,
  output logic                 requestEnq,
  input  logic                 requestNotFull,
  input  logic [`DATA_W-1:0]   indicationData,
  input  logic                 indicationNotEmpty,
  output logic                 indicationDeq,
  input  logic [`DATA_W-1:0]   indIntrChannel,
  input  logic [`DATA_W-1:0]   reqIntrChannel,
  output logic                 interrupt
);

  import portalPkg::*;

  logic [`OFFS_W-1:0] ctrlOffset;
  portSelT ctrlPort;
  logic [`DATA_W-1:0] ctrlWord;
  logic enableWrite;
  portSelT writePort;
  logic enableValue;

  axiReadPath readPath (
    .CLK(CLK), .RST_N(RST_N),
    .arAddr(arAddr), .arId(arId), .arLen(arLen), .arValid(arValid), .arReady(arReady),
    .rData(rData), .rId(rId), .rValid(rValid), .rReady(rReady),
    .ctrlOffset(ctrlOffset), .ctrlPort(ctrlPort), .ctrlWord(ctrlWord),
    .indicationData(indicationData), .indicationNotEmpty(indicationNotEmpty),
    .indicationDeq(indicationDeq), .requestNotFull(requestNotFull));

  axiWritePath writePath (
    .CLK(CLK), .RST_N(RST_N),
    .awAddr(awAddr), .awId(awId), .awLen(awLen), .awValid(awValid), .awReady(awReady),
    .wData(wData), .wLast(wLast), .wValid(wValid), .wReady(wReady),
    .bId(bId), .bValid(bValid), .bReady(bReady),
    .requestData(requestData), .requestSelect(requestSelect), .requestEnq(requestEnq),
    .requestNotFull(requestNotFull), .enableWrite(enableWrite), .writePort(writePort),
    .enableValue(enableValue));

  portalRegisters regs (
    .CLK(CLK), .RST_N(RST_N),
    .readPort(ctrlPort), .readOffset(ctrlOffset), .readWord(ctrlWord),
    .enableWrite(enableWrite), .writePort(writePort), .enableValue(enableValue),
    .indIntrChannel(indIntrChannel), .reqIntrChannel(reqIntrChannel),
    .interrupt(interrupt));

endmodule

/* bench/portalBench.sv */
`timescale 1ns/1ps

module portalBench;

  localparam int nCtrlReads = 12;
  localparam int nIrqRounds = 4;
  localparam int nReqWrites = 10;
  localparam int nIndReads = 10;
  localparam int nStress = 8;
  localparam int totalBursts = 2 + nCtrlReads + 3 * nIrqRounds + nReqWrites
                             + nIndReads + 2 * nStress;
  localparam int cycleLimit = totalBursts * 64;

  logic CLK, RST_N;
  logic [31:0] arAddr, awAddr, wData, rData, requestData;
  logic [31:0] indicationData, indIntrChannel, reqIntrChannel;
  logic [5:0] arId, awId, rId, bId;
  logic [3:0] arLen, awLen;
  logic [1:0] requestSelect;
  logic arValid, arReady, rValid, rReady, awValid, awReady;
  logic wLast, wValid, wReady, bValid, bReady;
  logic requestEnq, requestNotFull, indicationNotEmpty, indicationDeq, interrupt;

  logic [31:0] seed = 32'd77553;
  logic [31:0] indQ[$];          // Words the user side still offers
  logic [31:0] expReadData[$];
  logic [5:0] expReadId[$];
  logic [5:0] expBId[$];
  logic [33:0] expReq[$];        // {select, data}
  logic [1:0] enableModel;
  logic jitter;
  logic arFired, awFired, wFired;
  logic [4:0] idleSnap;
  logic intSeen, wReadySeen;
  string testName;
  int checks = 0;
  int errors = 0;
  int cycles;

  portalTop UUT (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < cycleLimit) begin
      @(posedge CLK);
      cycles++;
    end
    $display("Timeout: no finish within %0d cycles during %s", cycleLimit, testName);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Test FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return {seed[15:0], seed[31:16]};  // Low LCG bits are weak
  endfunction

  task automatic checkValue(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic checkTrue(logic cond, string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error in %s: %s", testName, msg);
    end
  endtask

  function automatic logic [31:0] ctrlExpect(logic port, logic [4:0] offs);
    logic [31:0] chan;
    chan = port ? reqIntrChannel : indIntrChannel;
    case (offs)
      5'h00: return {31'd0, chan != 32'd0};
      5'h04: return {31'd0, enableModel[port]};
      5'h08: return 32'd1;
      5'h0C: return chan;
      5'h10: return port ? 32'd6 : 32'd5;
      5'h14: return 32'd2;
      5'h18, 5'h1C: return 32'd0;
      default: return 32'h005A05A0;
    endcase
  endfunction

  function automatic logic expectInterrupt();
    return (indIntrChannel != 32'd0 && enableModel[0])
        || (reqIntrChannel != 32'd0 && enableModel[1]);
  endfunction

  function automatic int countDataBeats(logic [4:0] offs, logic [3:0] len);
    int n;
    int b;
    logic [4:0] o;
    n = 0;
    o = offs;
    for (b = 0; b <= int'(len); b++) begin
      if (o == 5'h00) n++;
      o = o + 5'd4;
    end
    return n;
  endfunction

  function automatic void refreshUser();
    indicationNotEmpty = indQ.size() != 0;
    indicationData = (indQ.size() != 0) ? indQ[0] : 32'd0;
  endfunction

  // One clock with monitors at the falling edge and the user side moving after the rising edge
  task automatic tick();
    logic deqSeen;
    logic [31:0] r;
    @(negedge CLK);
    idleSnap = {rValid, bValid, interrupt, requestEnq, indicationDeq};
    intSeen = interrupt;
    wReadySeen = wReady;
    if (rValid && rReady) begin
      checkTrue(expReadData.size() != 0, "read beat arrived with no burst outstanding");
      if (expReadData.size() != 0) begin
        checkValue({testName, " rData"}, expReadData.pop_front(), rData);
        checkValue({testName, " rId"}, 32'(expReadId.pop_front()), 32'(rId));
      end
    end
    if (bValid && bReady) begin
      checkTrue(expBId.size() != 0, "write response arrived with no burst outstanding");
      if (expBId.size() != 0) checkValue({testName, " bId"}, 32'(expBId.pop_front()), 32'(bId));
    end
    if (requestEnq) begin
      checkTrue(requestNotFull, "requestEnq pulsed while requestNotFull was low");
      checkTrue(expReq.size() != 0, "requestEnq pulsed with no write beat expected");
      if (expReq.size() != 0) begin
        checkValue({testName, " requestSelect"}, 32'(expReq[0][33:32]), 32'(requestSelect));
        checkValue({testName, " requestData"}, expReq[0][31:0], requestData);
        void'(expReq.pop_front());
      end
    end
    deqSeen = indicationDeq;
    if (deqSeen) checkTrue(indQ.size() != 0, "indicationDeq pulsed with no data offered");
    arFired = arValid && arReady;
    awFired = awValid && awReady;
    wFired = wValid && wReady;
    @(posedge CLK);
    #1;
    if (deqSeen && indQ.size() != 0) void'(indQ.pop_front());
    r = nextRand();
    if (jitter) begin
      rReady = r[0];
      bReady = r[1];
      requestNotFull = r[3:2] != 2'b00;
    end else begin
      rReady = 1'b1;
      bReady = 1'b1;
    end
    refreshUser();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Burst drivers
  task automatic issueRead(logic [31:0] addr, logic [5:0] id, logic [3:0] len);
    logic [4:0] offs;
    logic port;
    logic [31:0] word;
    int k;
    int b;
    offs = addr[4:0];
    port = addr[12];
    k = 0;
    for (b = 0; b <= int'(len); b++) begin
      if (addr[11:5] == 7'd0) begin
        word = ctrlExpect(port, offs);
      end else if (!port) begin
        if (offs == 5'h00) begin
          word = indQ[k];  // Each data beat takes the next queued word
          k++;
        end else begin
          word = (offs == 5'h04) ? {31'd0, indQ.size() > k} : 32'd0;
        end
      end else begin
        word = (offs == 5'h04) ? {31'd0, requestNotFull} : 32'd0;
      end
      expReadData.push_back(word);
      expReadId.push_back(id);
      offs = offs + 5'd4;
    end
    arAddr = addr;
    arId = id;
    arLen = len;
    arValid = 1'b1;
    arFired = 1'b0;
    while (!arFired) tick();
    arValid = 1'b0;
  endtask

  task automatic issueWrite(logic [31:0] addr, logic [5:0] id, logic [3:0] len,
                            logic [31:0] firstData);
    logic [4:0] offs;
    logic [31:0] data;
    logic [1:0] method;
    int b;
    offs = addr[4:0];
    method = addr[6:5] - 2'd1;
    expBId.push_back(id);
    awAddr = addr;
    awId = id;
    awLen = len;
    awValid = 1'b1;
    awFired = 1'b0;
    while (!awFired) tick();
    awValid = 1'b0;
    for (b = 0; b <= int'(len); b++) begin
      data = (b == 0) ? firstData : nextRand();
      if (addr[12] && addr[11:5] != 7'd0) expReq.push_back({method, data});
      if (addr[11:5] == 7'd0 && offs == 5'h04) enableModel[addr[12]] = data[0];
      wData = data;
      wLast = b == int'(len);
      wValid = 1'b1;
      wFired = 1'b0;
      while (!wFired) tick();
      offs = offs + 5'd4;
    end
    wValid = 1'b0;
    wLast = 1'b0;
    tick();
    checkTrue(!wReadySeen, "WREADY stayed high after the last write beat");
  endtask

  task automatic waitAll();
    while (expReadData.size() != 0 || expBId.size() != 0) tick();
    checkTrue(expReq.size() == 0, "request strobes missing after the write response");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin : stimulus
    logic [31:0] r;
    logic [6:0] page;
    logic port;
    int n0;
    int extra;
    int i;
    {arAddr, arId, arLen, arValid, awAddr, awId, awLen, awValid} = '0;
    {wData, wLast, wValid, indicationData, indicationNotEmpty} = '0;
    // Channels pending through reset so that the cleared enable bits alone hold interrupt low
    indIntrChannel = 32'h0000_0001;
    reqIntrChannel = 32'h8000_0000;
    rReady = 1'b1;
    bReady = 1'b1;
    requestNotFull = 1'b1;
    enableModel = 2'b00;
    jitter = 1'b0;
    testName = "reset";
    RST_N = 1'b0;
    repeat (5) @(posedge CLK);
    #1;
    RST_N = 1'b1;

    tick();
    checkValue("reset outputs", 32'd0, 32'(idleSnap));
    issueRead(32'h0000_0004, 6'd1, 4'd0);
    issueRead(32'h0000_1004, 6'd2, 4'd0);
    waitAll();

    testName = "control read";
    indIntrChannel = nextRand();
    r = nextRand();
    reqIntrChannel = r[0] ? r : 32'd0;
    for (i = 0; i < nCtrlReads; i++) begin
      r = nextRand();
      port = r[0];
      // Now and then an unaligned start lands on unmapped offsets
      issueRead({19'd0, port, 7'd0, (r[2:1] == 2'b00) ? r[7:3] : {r[7:5], 2'b00}},
                r[13:8], r[17:14]);
      waitAll();
    end

    testName = "interrupt enable";
    for (i = 0; i < nIrqRounds; i++) begin
      port = i[0];
      r = nextRand() | 32'd1;
      indIntrChannel = port ? 32'd0 : r;
      reqIntrChannel = port ? r : 32'd0;
      issueWrite({19'd0, port, 12'h004}, r[6:1], 4'd0, 32'd1);
      waitAll();
      tick();
      checkValue("interrupt after enable", 32'(expectInterrupt()), 32'(intSeen));
      issueRead({19'd0, port, 12'h004}, r[12:7], 4'd0);
      issueWrite({19'd0, port, 12'h004}, r[18:13], 4'd0, 32'd0);
      waitAll();
      tick();
      checkValue("interrupt after disable", 32'(expectInterrupt()), 32'(intSeen));
    end

    testName = "request write";
    jitter = 1'b1;
    for (i = 0; i < nReqWrites; i++) begin
      r = nextRand();
      page = (r[6:0] == 7'd0) ? 7'd1 : r[6:0];
      issueWrite({19'd0, 1'b1, page, r[9:7], 2'b00}, r[15:10], r[19:16], nextRand());
      waitAll();
    end
    jitter = 1'b0;
    requestNotFull = 1'b1;

    testName = "indication read";
    for (i = 0; i < nIndReads; i++) begin
      r = nextRand();
      page = (r[6:0] == 7'd0) ? 7'd1 : r[6:0];
      if (i % 4 == 3) begin
        requestNotFull = r[20];  // Held steady for the whole burst
        issueRead({19'd0, 1'b1, page, 5'h04}, r[26:21], {2'b00, r[11:10]});
        waitAll();
      end else begin
        n0 = countDataBeats({r[9:7], 2'b00}, r[13:10]);
        while (indQ.size() < n0 + int'(r[14])) indQ.push_back(nextRand());
        refreshUser();
        extra = indQ.size() - n0;
        issueRead({19'd0, 1'b0, page, r[9:7], 2'b00}, r[20:15], r[13:10]);
        waitAll();
        checkValue("indication words left", 32'(extra), 32'(indQ.size()));
      end
    end
    requestNotFull = 1'b1;

    testName = "back-pressure";
    jitter = 1'b1;
    for (i = 0; i < nStress; i++) begin
      r = nextRand();
      issueRead({19'd0, r[0], 7'd0, r[3:1], 2'b00}, r[9:4], r[13:10]);
      r = nextRand();
      page = (r[6:0] == 7'd0) ? 7'd1 : r[6:0];
      issueWrite({19'd0, 1'b1, page, r[9:7], 2'b00}, r[15:10], r[19:16], nextRand());
    end
    waitAll();
    jitter = 1'b0;

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
+incdir+design
design/portalPkg.sv
design/smallFifo.sv
design/burstSplitter.sv
design/portalRegisters.sv
design/axiReadPath.sv
design/axiWritePath.sv
design/portalTop.sv
bench/portalBench.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module portalBench -f project.f

output="$(./obj_dir/VportalBench)"
echo "$output"
if echo "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
